// ==== umi_pkg.sv ====
package umi_pkg;

  // ##########################################################
  // UMI opcodes
  // ##########################################################

  // Write request carrying data
  localparam logic [4:0] UMI_REQ_WRITE  = 5'h03;
  // Write acknowledge, no data
  localparam logic [4:0] UMI_RESP_WRITE = 5'h04;

  // ##########################################################
  // UMI command word
  // ##########################################################

  // One 32-bit command, decoded as request or as response
  // Atomic type shares the len byte on atomic opcodes
  // User extension shares bits 31:8 on user opcodes
  // Neither opcode class is handled here
  typedef union packed {
    struct packed {
      logic [4:0] hostid;
      logic [1:0] user;
      logic       ex;
      logic       eof;
      logic       eom;
      logic [1:0] prot;
      logic [3:0] qos;
      logic [7:0] len;
      logic [2:0] size;
      logic [4:0] opcode;
    } req;
    struct packed {
      logic [4:0] hostid;
      // Same bits as user, carries the error code in responses
      logic [1:0] err;
      logic       ex;
      logic       eof;
      logic       eom;
      logic [1:0] prot;
      logic [3:0] qos;
      logic [7:0] len;
      logic [2:0] size;
      logic [4:0] opcode;
    } resp;
  } umi_cmd_t;

  // ##########################################################
  // AXI codes
  // ##########################################################

  localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
  localparam logic [1:0] AXI_BURST_INCR  = 2'b01;
  localparam logic [1:0] AXI_BURST_WRAP  = 2'b10;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

// ==== umi_if.sv ====
`timescale 1ns/100ps

// One UMI channel, valid/ready handshake
interface umi_if #(
  parameter int DW = 32,
  parameter int AW = 32
);

  logic             valid;
  umi_pkg::umi_cmd_t cmd;
  logic [AW-1:0]    dstaddr;
  logic [AW-1:0]    srcaddr;
  logic [DW-1:0]    data;
  logic             ready;

  // Sender holds valid and fields until the transfer
  modport sender (
    output valid, cmd, dstaddr, srcaddr, data,
    input  ready
  );

  modport receiver (
    input  valid, cmd, dstaddr, srcaddr, data,
    output ready
  );

endinterface

// ==== axiwr2umi.sv ====
`timescale 1ns/100ps

module axiwr2umi #(
  parameter int            DW       = 32,
  parameter int            AW       = 32,
  parameter int            IDW      = 4,
  // Low DW/8 bits get replaced by the write strobe
  parameter logic [AW-1:0] HOSTADDR = '0
) (
  input  logic             clk,
  input  logic             nreset,

  // AXI write address channel
  input  logic [IDW-1:0]   s_axi_awid,
  input  logic [AW-1:0]    s_axi_awaddr,
  input  logic [7:0]       s_axi_awlen,
  input  logic [2:0]       s_axi_awsize,
  input  logic [1:0]       s_axi_awburst,
  input  logic [2:0]       s_axi_awprot,
  input  logic [3:0]       s_axi_awqos,
  input  logic             s_axi_awvalid,
  output logic             s_axi_awready,

  // AXI write data channel
  input  logic [DW-1:0]    s_axi_wdata,
  input  logic [DW/8-1:0]  s_axi_wstrb,
  input  logic             s_axi_wlast,
  input  logic             s_axi_wvalid,
  output logic             s_axi_wready,

  // AXI write response channel
  output logic [IDW-1:0]   s_axi_bid,
  output logic [1:0]       s_axi_bresp,
  output logic             s_axi_bvalid,
  input  logic             s_axi_bready,

  // UMI request out and response back
  umi_if.sender            req,
  umi_if.receiver          resp
);

  localparam int STRBW = DW / 8;
  localparam int CNTW  = $clog2(STRBW) + 1;

  // FSM encoding
  localparam logic [1:0] ST_IDLE      = 2'd0;
  localparam logic [1:0] ST_WRITE     = 2'd1;
  localparam logic [1:0] ST_WAIT_RESP = 2'd2;
  localparam logic [1:0] ST_SEND_B    = 2'd3;

  logic [1:0]        state;
  logic [1:0]        next_state;
  logic [8:0]        beats_left;
  logic [AW-1:0]     dst_addr;
  logic [AW-1:0]     beat_bytes;
  logic [IDW-1:0]    aw_id;
  logic [2:0]        aw_size;
  logic [1:0]        aw_burst;
  logic [1:0]        aw_prot;
  logic [3:0]        aw_qos;
  logic [1:0]        bresp_err;
  logic [CNTW-1:0]   strb_cnt;
  umi_pkg::umi_cmd_t req_cmd;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic resp_fire;
  logic empty_beat;
  logic last_beat;
  logic addr_step;

  // ##########################################################
  // Handshakes
  // ##########################################################

  assign aw_fire   = s_axi_awvalid & s_axi_awready;
  assign w_fire    = s_axi_wvalid & s_axi_wready;
  assign b_fire    = s_axi_bvalid & s_axi_bready;
  assign resp_fire = resp.valid & resp.ready;

  // Zero strobe carries no bytes and sends no request
  assign empty_beat = (s_axi_wstrb == '0);
  // Early wlast also closes the burst
  assign last_beat  = (beats_left == 9'd1) | s_axi_wlast;

  // ##########################################################
  // Address channel capture
  // ##########################################################

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_id    <= s_axi_awid;
      aw_size  <= s_axi_awsize;
      aw_burst <= s_axi_awburst;
      // Only privileged and secure bits map to UMI
      aw_prot  <= s_axi_awprot[1:0];
      aw_qos   <= s_axi_awqos;
    end
  end

  // Remaining beats drop to zero once the last beat is taken
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      beats_left <= '0;
    end else if (aw_fire) begin
      beats_left <= {1'b0, s_axi_awlen} + 9'd1;
    end else if (w_fire) begin
      beats_left <= last_beat ? 9'd0 : beats_left - 9'd1;
    end
  end

  // Address step per beat with WRAP treated as FIXED
  always_comb begin
    case (aw_burst)
      umi_pkg::AXI_BURST_INCR:  addr_step = 1'b1;
      umi_pkg::AXI_BURST_FIXED: addr_step = 1'b0;
      umi_pkg::AXI_BURST_WRAP:  addr_step = 1'b0;
      default:                  addr_step = 1'b0;
    endcase
  end

  assign beat_bytes = {{(AW-1){1'b0}}, 1'b1} << aw_size;

  // Empty beats still advance the address
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      dst_addr <= s_axi_awaddr;
    end else if (w_fire && addr_step) begin
      dst_addr <= dst_addr + beat_bytes;
    end
  end

  // ##########################################################
  // Request path
  // ##########################################################

  // Contiguous strobe from lane 0 gives the byte length as its count
  always_comb begin
    strb_cnt = '0;
    for (int i = 0; i < STRBW; i++) begin
      strb_cnt = strb_cnt + CNTW'(s_axi_wstrb[i]);
    end
  end

  always_comb begin
    req_cmd            = '0;
    req_cmd.req.opcode = umi_pkg::UMI_REQ_WRITE;
    // Byte count goes in len and size stays 0
    req_cmd.req.size   = 3'b000;
    req_cmd.req.len    = 8'(strb_cnt) - 8'd1;
    req_cmd.req.prot   = aw_prot;
    req_cmd.req.qos    = aw_qos;
    // Each beat is its own message
    req_cmd.req.eom    = 1'b1;
  end

  assign req.valid   = (state == ST_WRITE) & s_axi_wvalid & ~empty_beat;
  assign req.cmd     = req_cmd;
  assign req.dstaddr = dst_addr;
  // Strobe rides in the low source address bits
  assign req.srcaddr = {HOSTADDR[AW-1:STRBW], s_axi_wstrb};
  assign req.data    = s_axi_wdata;

  // Beat taken with its request or alone when empty
  assign s_axi_wready = (state == ST_WRITE) & (req.ready | empty_beat);

  // ##########################################################
  // Response path
  // ##########################################################

  assign resp.ready = (state == ST_WAIT_RESP);

  // Error latch cleared on each address accept
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      bresp_err <= umi_pkg::AXI_RESP_OKAY;
    end else if (aw_fire) begin
      bresp_err <= umi_pkg::AXI_RESP_OKAY;
    end else if (resp_fire) begin
      if (resp.cmd.resp.opcode != umi_pkg::UMI_RESP_WRITE) begin
        bresp_err <= umi_pkg::AXI_RESP_SLVERR;
      end else if (resp.cmd.resp.err != umi_pkg::AXI_RESP_OKAY) begin
        bresp_err <= resp.cmd.resp.err;
      end
    end
  end

  assign s_axi_bid    = aw_id;
  assign s_axi_bresp  = bresp_err;
  assign s_axi_bvalid = (state == ST_SEND_B);

  // ##########################################################
  // FSM
  // ##########################################################

  assign s_axi_awready = (state == ST_IDLE);

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (s_axi_awvalid) next_state = ST_WRITE;
      end
      ST_WRITE: begin
        // Request sent or empty beat skipped
        if (w_fire) begin
          if (!empty_beat) begin
            next_state = ST_WAIT_RESP;
          end else if (last_beat) begin
            next_state = ST_SEND_B;
          end
        end
      end
      ST_WAIT_RESP: begin
        if (resp_fire) begin
          next_state = (beats_left == 9'd0) ? ST_SEND_B : ST_WRITE;
        end
      end
      ST_SEND_B: begin
        if (b_fire) next_state = ST_IDLE;
      end
      default: next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

endmodule

// ==== umi_mem_target.sv ====
`timescale 1ns/100ps

module umi_mem_target #(
  parameter int DW        = 32,
  parameter int AW        = 32,
  // Power of two
  parameter int MEM_BYTES = 256
) (
  input  logic          clk,
  input  logic          nreset,
  umi_if.receiver       req,
  umi_if.sender         resp,
  input  logic [AW-1:0] rd_addr,
  output logic [DW-1:0] rd_data
);

  localparam int LANES = DW / 8;
  localparam int AB    = $clog2(MEM_BYTES);

  logic [7:0]        mem [MEM_BYTES];
  logic [AW:0]       end_addr;
  logic [AB-1:0]     wr_base;
  logic [1:0]        err;
  logic              req_fire;
  logic              resp_fire;
  logic              in_range;
  logic              op_ok;
  logic              wr_ok;
  logic              resp_valid;
  umi_pkg::umi_cmd_t next_cmd;
  umi_pkg::umi_cmd_t resp_cmd;
  logic [AW-1:0]     resp_dstaddr;
  logic [AW-1:0]     resp_srcaddr;

  // ##########################################################
  // Request decode
  // ##########################################################

  // One response pending at most
  assign req.ready = ~resp_valid;
  assign req_fire  = req.valid & req.ready;
  assign resp_fire = resp.valid & resp.ready;

  // Last byte address, extra bit against wrap
  assign end_addr = {1'b0, req.dstaddr} + (AW+1)'(req.cmd.req.len);
  assign in_range = end_addr < (AW+1)'(MEM_BYTES);
  assign op_ok    = (req.cmd.req.opcode == umi_pkg::UMI_REQ_WRITE);
  assign wr_ok    = req_fire & in_range & op_ok;
  assign err      = (in_range & op_ok) ? umi_pkg::AXI_RESP_OKAY : umi_pkg::AXI_RESP_SLVERR;

  // Range check keeps the base plus len inside the array
  assign wr_base = req.dstaddr[AB-1:0];

  // Bytes 0..len from the low lanes
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      for (int i = 0; i < LANES; i++) begin
        if (i <= int'(req.cmd.req.len)) begin
          mem[wr_base + AB'(i)] <= req.data[8*i +: 8];
        end
      end
    end
  end

  // ##########################################################
  // Write response
  // ##########################################################

  always_comb begin
    next_cmd             = '0;
    next_cmd.resp.opcode = umi_pkg::UMI_RESP_WRITE;
    next_cmd.resp.err    = err;
    next_cmd.resp.hostid = req.cmd.req.hostid;
    next_cmd.resp.eom    = 1'b1;
  end

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      resp_valid <= 1'b0;
    end else if (req_fire) begin
      resp_valid <= 1'b1;
    end else if (resp_fire) begin
      resp_valid <= 1'b0;
    end
  end

  // Return path swaps source and destination
  always_ff @(posedge clk) begin
    if (req_fire) begin
      resp_cmd     <= next_cmd;
      resp_dstaddr <= req.srcaddr;
      resp_srcaddr <= req.dstaddr;
    end
  end

  assign resp.valid   = resp_valid;
  assign resp.cmd     = resp_cmd;
  assign resp.dstaddr = resp_dstaddr;
  assign resp.srcaddr = resp_srcaddr;
  assign resp.data    = '0;

  // ##########################################################
  // Read port
  // ##########################################################

  // One cycle latency, bytes past the end read as zero
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      if (({1'b0, rd_addr} + (AW+1)'(i)) < (AW+1)'(MEM_BYTES)) begin
        rd_data[8*i +: 8] <= mem[rd_addr[AB-1:0] + AB'(i)];
      end else begin
        rd_data[8*i +: 8] <= 8'h00;
      end
    end
  end

endmodule

// ==== axi2umi_wr_top.sv ====
`timescale 1ns/100ps

module axi2umi_wr_top #(
  parameter int            DW        = 32,
  parameter int            AW        = 32,
  parameter int            IDW       = 4,
  parameter logic [AW-1:0] HOSTADDR  = '0,
  parameter int            MEM_BYTES = 256
) (
  input  logic             clk,
  input  logic             nreset,

  // AXI write address
  input  logic [IDW-1:0]   s_axi_awid,
  input  logic [AW-1:0]    s_axi_awaddr,
  input  logic [7:0]       s_axi_awlen,
  input  logic [2:0]       s_axi_awsize,
  input  logic [1:0]       s_axi_awburst,
  input  logic [2:0]       s_axi_awprot,
  input  logic [3:0]       s_axi_awqos,
  input  logic             s_axi_awvalid,
  output logic             s_axi_awready,

  // AXI write data
  input  logic [DW-1:0]    s_axi_wdata,
  input  logic [DW/8-1:0]  s_axi_wstrb,
  input  logic             s_axi_wlast,
  input  logic             s_axi_wvalid,
  output logic             s_axi_wready,

  // AXI write response
  output logic [IDW-1:0]   s_axi_bid,
  output logic [1:0]       s_axi_bresp,
  output logic             s_axi_bvalid,
  input  logic             s_axi_bready,

  // Memory readback
  input  logic [AW-1:0]    rd_addr,
  output logic [DW-1:0]    rd_data
);

  // Bridge to target, and back
  umi_if #(.DW(DW), .AW(AW)) req_ch ();
  umi_if #(.DW(DW), .AW(AW)) resp_ch ();

  axiwr2umi #(
    .DW       (DW),
    .AW       (AW),
    .IDW      (IDW),
    .HOSTADDR (HOSTADDR)
  ) axiwr2umi_inst (
    .clk           (clk),
    .nreset        (nreset),
    .s_axi_awid    (s_axi_awid),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awlen   (s_axi_awlen),
    .s_axi_awsize  (s_axi_awsize),
    .s_axi_awburst (s_axi_awburst),
    .s_axi_awprot  (s_axi_awprot),
    .s_axi_awqos   (s_axi_awqos),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wlast   (s_axi_wlast),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bid     (s_axi_bid),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .req           (req_ch.sender),
    .resp          (resp_ch.receiver)
  );

  umi_mem_target #(
    .DW        (DW),
    .AW        (AW),
    .MEM_BYTES (MEM_BYTES)
  ) umi_mem_target_inst (
    .clk     (clk),
    .nreset  (nreset),
    .req     (req_ch.receiver),
    .resp    (resp_ch.sender),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/100ps

// Free-running clock, reset released on a falling edge
module tb_clkgen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic nreset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset held low over the first rising edges
  initial begin
    nreset = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    nreset = 1'b1;
  end

endmodule

// ==== axi2umi_wr_asserts.sv ====
`timescale 1ns/100ps

// Handshake properties of the bridge, bound into every axiwr2umi
module axi2umi_wr_asserts #(
  parameter int DW  = 32,
  parameter int AW  = 32,
  parameter int IDW = 4
) (
  input logic           clk,
  input logic           nreset,
  input logic           s_axi_awready,
  input logic           s_axi_wvalid,
  input logic           s_axi_wready,
  input logic [IDW-1:0] s_axi_bid,
  input logic [1:0]     s_axi_bresp,
  input logic           s_axi_bvalid,
  input logic           s_axi_bready,
  input logic           req_valid,
  input logic           req_ready,
  input logic [31:0]    req_cmd,
  input logic [AW-1:0]  req_dstaddr,
  input logic [AW-1:0]  req_srcaddr,
  input logic [DW-1:0]  req_data
);

  // B channel held with its fields until taken
  b_hold: assert property (@(posedge clk) disable iff (!nreset)
    s_axi_bvalid && !s_axi_bready |=>
      s_axi_bvalid && $stable(s_axi_bid) && $stable(s_axi_bresp))
    else $error("bvalid or its fields changed before bready");

  // A request only exists for a live data beat
  req_needs_beat: assert property (@(posedge clk) disable iff (!nreset)
    req_valid |-> s_axi_wvalid)
    else $error("UMI request without a write data beat");

  // Address and data phases are exclusive
  aw_w_exclusive: assert property (@(posedge clk) disable iff (!nreset)
    !(s_axi_awready && s_axi_wready))
    else $error("awready and wready high together");

  // Stalled request keeps valid and every field
  req_stable: assert property (@(posedge clk) disable iff (!nreset)
    req_valid && !req_ready |=>
      req_valid && $stable({req_cmd, req_dstaddr, req_srcaddr, req_data}))
    else $error("UMI request changed while stalled");

endmodule

bind axiwr2umi axi2umi_wr_asserts #(
  .DW  (DW),
  .AW  (AW),
  .IDW (IDW)
) axi2umi_wr_asserts_inst (
  .clk           (clk),
  .nreset        (nreset),
  .s_axi_awready (s_axi_awready),
  .s_axi_wvalid  (s_axi_wvalid),
  .s_axi_wready  (s_axi_wready),
  .s_axi_bid     (s_axi_bid),
  .s_axi_bresp   (s_axi_bresp),
  .s_axi_bvalid  (s_axi_bvalid),
  .s_axi_bready  (s_axi_bready),
  .req_valid     (req.valid),
  .req_ready     (req.ready),
  .req_cmd       (req.cmd),
  .req_dstaddr   (req.dstaddr),
  .req_srcaddr   (req.srcaddr),
  .req_data      (req.data)
);

// ==== axi2umi_wr_tb.sv ====
`timescale 1ns/100ps

module axi2umi_wr_tb;

  localparam int DW              = 32;
  localparam int AW              = 32;
  localparam int IDW             = 4;
  localparam int MEM_BYTES       = 256;
  localparam int CLK_PERIOD      = 10;
  localparam int STIM_DEPTH      = 256;
  // Watchdog budget per input word
  localparam int CYCLES_PER_WORD = 20;

  logic            clk;
  logic            nreset;
  logic [IDW-1:0]  s_axi_awid;
  logic [AW-1:0]   s_axi_awaddr;
  logic [7:0]      s_axi_awlen;
  logic [2:0]      s_axi_awsize;
  logic [1:0]      s_axi_awburst;
  logic [2:0]      s_axi_awprot;
  logic [3:0]      s_axi_awqos;
  logic            s_axi_awvalid;
  logic            s_axi_awready;
  logic [DW-1:0]   s_axi_wdata;
  logic [DW/8-1:0] s_axi_wstrb;
  logic            s_axi_wlast;
  logic            s_axi_wvalid;
  logic            s_axi_wready;
  logic [IDW-1:0]  s_axi_bid;
  logic [1:0]      s_axi_bresp;
  logic            s_axi_bvalid;
  logic            s_axi_bready;
  logic [AW-1:0]   rd_addr;
  logic [DW-1:0]   rd_data;

  logic [31:0] stim [0:STIM_DEPTH-1];
  int          stim_words    = 0;
  int          checks_failed = 0;
  integer      seed          = 32'hf2c6c9f2;

  // Handshakes seen at the last rising edge
  logic aw_done = 1'b0;
  logic w_done  = 1'b0;
  int   b_count = 0;

  tb_clkgen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) tb_clkgen_inst (
    .clk    (clk),
    .nreset (nreset)
  );

  axi2umi_wr_top #(
    .DW        (DW),
    .AW        (AW),
    .IDW       (IDW),
    .HOSTADDR  (32'h0001_0000),
    .MEM_BYTES (MEM_BYTES)
  ) axi2umi_wr_top_inst (
    .clk           (clk),
    .nreset        (nreset),
    .s_axi_awid    (s_axi_awid),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awlen   (s_axi_awlen),
    .s_axi_awsize  (s_axi_awsize),
    .s_axi_awburst (s_axi_awburst),
    .s_axi_awprot  (s_axi_awprot),
    .s_axi_awqos   (s_axi_awqos),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wlast   (s_axi_wlast),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bid     (s_axi_bid),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data)
  );

  // Pre-edge values, so no race with the DUT flops
  always @(posedge clk) begin
    aw_done <= s_axi_awvalid & s_axi_awready;
    w_done  <= s_axi_wvalid & s_axi_wready;
    if (s_axi_bvalid && s_axi_bready) begin
      b_count <= b_count + 1;
    end
  end

  // ##########################################################
  // Checking helpers
  // ##########################################################

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      checks_failed++;
      $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // Walks the records, returns words used plus end marker
  function automatic int count_words();
    int pos;
    pos = 0;
    while (pos < STIM_DEPTH) begin
      if (stim[pos] === 32'd1) begin
        pos += 7 + 2 * (int'(stim[pos+3][7:0]) + 1);
      end else if (stim[pos] === 32'd2) begin
        pos += 3;
      end else begin
        break;
      end
    end
    return pos + 1;
  endfunction

  // ##########################################################
  // AXI drivers, all entered on a falling edge
  // ##########################################################

  task automatic send_addr(input logic [IDW-1:0] id, input logic [AW-1:0] addr,
                           input logic [7:0] len, input logic [2:0] size,
                           input logic [1:0] burst);
    s_axi_awid    = id;
    s_axi_awaddr  = addr;
    s_axi_awlen   = len;
    s_axi_awsize  = size;
    s_axi_awburst = burst;
    s_axi_awvalid = 1'b1;
    do @(negedge clk); while (!aw_done);
    s_axi_awvalid = 1'b0;
  endtask

  task automatic send_beat(input logic [DW-1:0] data, input logic [DW/8-1:0] strb,
                           input logic last);
    s_axi_wdata  = data;
    s_axi_wstrb  = strb;
    s_axi_wlast  = last;
    s_axi_wvalid = 1'b1;
    do @(negedge clk); while (!w_done);
    s_axi_wvalid = 1'b0;
    s_axi_wlast  = 1'b0;
  endtask

  // Random bready stall, B fields watched while held
  task automatic collect_b(input logic [IDW-1:0] id, input logic [1:0] exp_resp);
    int             stall;
    logic [IDW-1:0] bid_seen;
    logic [1:0]     bresp_seen;
    while (!s_axi_bvalid) @(negedge clk);
    bid_seen   = s_axi_bid;
    bresp_seen = s_axi_bresp;
    stall      = int'($unsigned($random(seed)) % 4);
    repeat (stall) begin
      @(negedge clk);
      check_value(32'(s_axi_bvalid), 32'd1, "bvalid dropped during stall");
      check_value(32'(s_axi_bid), 32'(bid_seen), "bid changed during stall");
      check_value(32'(s_axi_bresp), 32'(bresp_seen), "bresp changed during stall");
    end
    check_value(32'(s_axi_bid), 32'(id), "bid");
    check_value(32'(s_axi_bresp), 32'(exp_resp), "bresp");
    s_axi_bready = 1'b1;
    @(negedge clk);
    s_axi_bready = 1'b0;
    check_value(32'(s_axi_bvalid), 32'd0, "bvalid after accept");
  endtask

  // Header words, then one data and strobe pair per beat
  task automatic run_burst(input int pos);
    logic [7:0] len;
    len = stim[pos+3][7:0];
    send_addr(stim[pos+1][IDW-1:0], stim[pos+2], len, stim[pos+4][2:0],
              stim[pos+5][1:0]);
    for (int i = 0; i <= int'(len); i++) begin
      send_beat(stim[pos+7+2*i], stim[pos+8+2*i][DW/8-1:0], i == int'(len));
    end
    collect_b(stim[pos+1][IDW-1:0], stim[pos+6][1:0]);
  endtask

  // Read data registered, ready one edge later
  task automatic check_read(input logic [AW-1:0] addr, input logic [DW-1:0] exp);
    rd_addr = addr;
    @(negedge clk);
    check_value(rd_data, exp, $sformatf("readback at %h", addr));
  endtask

  // ##########################################################
  // Main sequence
  // ##########################################################

  initial begin
    int pos;
    int bursts;
    s_axi_awid    = '0;
    s_axi_awaddr  = '0;
    s_axi_awlen   = '0;
    s_axi_awsize  = '0;
    s_axi_awburst = '0;
    s_axi_awprot  = 3'b001;
    s_axi_awqos   = 4'h3;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wlast   = 1'b0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    rd_addr       = '0;
    $readmemh("axi2umi_wr_input.txt", stim);
    stim_words = count_words();
    wait (nreset === 1'b1);
    @(negedge clk);
    // Idle state out of reset
    check_value(32'(s_axi_awready), 32'd1, "awready after reset");
    check_value(32'(s_axi_wready), 32'd0, "wready after reset");
    check_value(32'(s_axi_bvalid), 32'd0, "bvalid after reset");
    pos    = 0;
    bursts = 0;
    while (stim[pos] !== 32'd0) begin
      if (stim[pos] === 32'd1) begin
        run_burst(pos);
        bursts++;
        check_value(32'(b_count), 32'(bursts), "B responses per burst");
        pos += 7 + 2 * (int'(stim[pos+3][7:0]) + 1);
      end else if (stim[pos] === 32'd2) begin
        check_read(stim[pos+1], stim[pos+2]);
        pos += 3;
      end else begin
        $display("input file has an unknown record type at word %0d", pos);
        stop_run();
      end
    end
    if (checks_failed == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_run();
    end
  end

  // Watchdog scaled by the size of the input file
  initial begin
    wait (stim_words != 0);
    #(stim_words * CYCLES_PER_WORD * CLK_PERIOD);
    $display("timeout, run did not finish within %0d cycles",
             stim_words * CYCLES_PER_WORD);
    stop_run();
  end

endmodule

// ==== axi2umi_wr_input.txt ====
// Burst: 1 id addr len size burst bresp, then len+1 pairs of data strb
// Readback: 2 addr expected_word; a lone 0 ends the file
// Single INCR beat, full strobe
1 3 00000010 00 2 1 0  DEADBEEF f
2 00000010 DEADBEEF
// Four-beat INCR, addr steps by 4
1 5 00000020 03 2 1 0  11111111 f 22222222 f 33333333 f 44444444 f
2 00000020 11111111
2 00000024 22222222
2 00000028 33333333
2 0000002C 44444444
// FIXED burst, last beat wins
1 7 00000040 02 2 0 0  A0A0A0A0 f B1B1B1B1 f C2C2C2C2 f
2 00000040 C2C2C2C2
// Partial strobes, empty third beat still steps the address
1 9 00000020 03 2 1 0  000000AA 1 0000BBCC 3 55555555 0 00DDEEFF 7
2 00000020 111111AA
2 00000024 2222BBCC
2 00000028 33333333
2 0000002C 44DDEEFF
// Empty last beat closes the burst
1 2 00000030 01 2 1 0  77777777 f 88888888 0
2 00000030 77777777
// Fill the top of memory
1 4 000000F8 01 2 1 0  66666666 f 99999999 f
2 000000F8 66666666
2 000000FC 99999999
// FIXED at FE, middle beat runs past the end
1 A 000000FE 02 1 0 2  0000A55A 3 12345678 f 000000C3 1
2 000000FC A5C39999
2 000000FE 0000A5C3
// Error cleared by the next burst
1 B 00000050 00 2 1 0  0BADF00D f
2 00000050 0BADF00D
// Eight-beat INCR
1 F 00000080 07 2 1 0  80808080 f 81818181 f 82828282 f 83838383 f
84848484 f 85858585 f 86868686 f 87878787 f
2 00000080 80808080
2 0000009C 87878787
0

// ==== axi2umi_wr.f ====
umi_pkg.sv
umi_if.sv
axiwr2umi.sv
umi_mem_target.sv
axi2umi_wr_top.sv
tb_clkgen.sv
axi2umi_wr_asserts.sv
axi2umi_wr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := axi2umi_wr_tb
FILELIST  := axi2umi_wr.f
OBJ_DIR   := obj_dir

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM) axi2umi_wr_input.txt
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
